/* run_sim.sh */
#!/bin/sh
# Build and run the configuration table testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cfg_table_tb \
    -f sim.f

# Run the simulation
out=$(./obj_dir/Vcfg_table_tb +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -q -F "All tests passed!"
then
    exit 0
fi
exit 1

/* sim.f */
verilog/cfg_pkg.sv
verilog/cfg_delay_pipe.sv
verilog/cfg_ram.sv
verilog/cfg_cpu_fsm.sv
verilog/cfg_scan_counter.sv
verilog/cfg_port_arb.sv
verilog/cfg_table_top.sv
test/cfg_table_assert.sv
test/cfg_table_tb.sv

/* test/cfg_table_assert.sv */
////////////////////
// Configuration table port checks
// Reset values, uprdy pulse rules, updo gating and sticky par_err
////////////////////
`timescale 1ns/1ps

module cfg_table_assert
(
    input logic               clk,
    input logic               rst,
    input logic               upen,
    input logic               upws,
    input logic               uprs,
    input logic               uprdy,
    input cfg_pkg::cfg_data_t updo,
    input logic               eng_valid,
    input logic               par_err
);

    // Failed assertions so far, read by the testbench
    int unsigned fail_count = 0;

    // A strobe arrived since the last uprdy
    logic strobe_seen;

    always_ff @(posedge clk)
    begin
        if (rst)
            strobe_seen <= 1'b0;
        // Strobes in the ready cycle are ignored by the FSM
        else if (uprdy)
            strobe_seen <= 1'b0;
        else if (upen && (upws || uprs))
            strobe_seen <= 1'b1;
    end

    ////////////////////
    // Reset leaves the outputs quiet
    reset_idle: assert property (@(posedge clk) rst |=> (!uprdy && !eng_valid && !par_err))
    else
    begin
        fail_count++;
        $error("uprdy, eng_valid or par_err high in the cycle after reset");
    end

    ////////////////////
    // uprdy rules
    rdy_pulse: assert property (@(posedge clk) disable iff (rst) uprdy |=> !uprdy)
    else
    begin
        fail_count++;
        $error("uprdy stayed high for more than one cycle");
    end

    rdy_needs_strobe: assert property (@(posedge clk) disable iff (rst) uprdy |-> strobe_seen)
    else
    begin
        fail_count++;
        $error("uprdy pulsed with no strobe since the previous uprdy");
    end

    // Read data hidden while the port is disabled
    updo_gated: assert property (@(posedge clk) disable iff (rst) !upen |-> (updo == '0))
    else
    begin
        fail_count++;
        $error("updo not zero while upen is low");
    end

    // Only rst clears the parity flag
    par_sticky: assert property (@(posedge clk) disable iff (rst) par_err |=> par_err)
    else
    begin
        fail_count++;
        $error("par_err dropped without a reset");
    end

endmodule

bind cfg_table_top cfg_table_assert u_assert
(
    .clk       (clk),
    .rst       (rst),
    .upen      (upen),
    .upws      (upws),
    .uprs      (uprs),
    .uprdy     (uprdy),
    .updo      (updo),
    .eng_valid (eng_valid),
    .par_err   (par_err)
);

/* test/cfg_table_tb.sv */
////////////////////
// Configuration table testbench
// CPU writes and reads, engine scan stream, collision forwarding
// and parity flag behaviour checked against a reference table
////////////////////
`timescale 1ns/1ps

module cfg_table_tb;

    // Operation counts per phase that also size the watchdog
    localparam int N_FILL  = cfg_pkg::DEPTH;
    localparam int N_RD    = 16;
    localparam int N_SCAN  = 24;
    localparam int N_COLL  = 8;
    localparam int NUM_OPS = N_FILL + N_RD + N_SCAN + 3 * N_COLL + 8;

    logic               clk;
    logic               rst;
    logic               upen;
    logic               upws;
    logic               uprs;
    cfg_pkg::cfg_addr_t upa;
    cfg_pkg::cfg_data_t updi;
    cfg_pkg::cfg_data_t updo;
    logic               uprdy;
    logic               active;
    logic               eng_valid;
    cfg_pkg::cfg_addr_t eng_addr;
    cfg_pkg::cfg_data_t eng_data;
    logic               par_force_err;
    logic               par_err_dis;
    logic               par_err;

    // Scanner enable with random idle cycles on top
    logic               scan_on;
    logic               gaps_on;
    logic               gap = 1'b0;

    // Table as the CPU sees it
    cfg_pkg::cfg_data_t model [cfg_pkg::DEPTH];
    // Table as the engine outputs see it with each write landing late
    cfg_pkg::cfg_data_t eng_view [cfg_pkg::DEPTH];
    int unsigned        due_q [$];
    cfg_pkg::cfg_addr_t wa_q [$];
    cfg_pkg::cfg_data_t wd_q [$];

    int unsigned        cyc = 0;
    int unsigned        errors = 0;
    int unsigned        eng_count = 0;
    logic               have_prev = 1'b0;
    cfg_pkg::cfg_addr_t prev_addr;

    cfg_table_top dut
    (
        .clk           (clk),
        .rst           (rst),
        .upen          (upen),
        .upws          (upws),
        .uprs          (uprs),
        .upa           (upa),
        .updi          (updi),
        .updo          (updo),
        .uprdy         (uprdy),
        .active        (active),
        .eng_valid     (eng_valid),
        .eng_addr      (eng_addr),
        .eng_data      (eng_data),
        .par_force_err (par_force_err),
        .par_err_dis   (par_err_dis),
        .par_err       (par_err)
    );

    ////////////////////
    // Clock, cycle count, scan gaps
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    always @(posedge clk)
    begin
        #1;
        gap = gaps_on && ($urandom_range(3) == 0);
    end

    assign active = scan_on && !gap;

    ////////////////////
    // Engine stream monitor
    always @(negedge clk)
    begin
        // Writes become visible once a read issued after them returns
        while (due_q.size() > 0 && due_q[0] <= cyc)
        begin
            eng_view[wa_q[0]] = wd_q[0];
            due_q.delete(0);
            wa_q.delete(0);
            wd_q.delete(0);
        end
        if (rst)
            have_prev = 1'b0;
        else if (eng_valid)
        begin
            eng_count++;
            assert (eng_data == eng_view[eng_addr])
            else
            begin
                errors++;
                $display("Error: eng_data at address %h is %h, expected %h",
                         eng_addr, eng_data, eng_view[eng_addr]);
            end
            assert (!have_prev ||
                    eng_addr == cfg_pkg::cfg_addr_t'((prev_addr + 1) % cfg_pkg::DEPTH))
            else
            begin
                errors++;
                $display("Error: eng_addr is %h, expected %h", eng_addr,
                         cfg_pkg::cfg_addr_t'((prev_addr + 1) % cfg_pkg::DEPTH));
            end
            prev_addr = eng_addr;
            have_prev = 1'b1;
        end
    end

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // One strobe then wait for uprdy
    // lat counts cycles from the strobe
    task automatic cpu_access(input logic wr, input cfg_pkg::cfg_addr_t addr,
                              input cfg_pkg::cfg_data_t data, output int unsigned lat);
        int unsigned start;
        int unsigned wait_cnt;
        @(posedge clk);
        #1;
        upa   = addr;
        updi  = data;
        upws  = wr;
        uprs  = !wr;
        start = cyc;
        if (wr)
        begin
            model[addr] = data;
            due_q.push_back(cyc + cfg_pkg::WR_LAT + cfg_pkg::RD_LAT);
            wa_q.push_back(addr);
            wd_q.push_back(data);
        end
        @(posedge clk);
        #1;
        upws = 1'b0;
        uprs = 1'b0;
        wait_cnt = 0;
        do
        begin
            @(negedge clk);
            wait_cnt++;
        end
        while (!uprdy && wait_cnt < cfg_pkg::DEPTH + 2 * cfg_pkg::RDY_LAT);
        lat = cyc - start;
        if (!uprdy)
        begin
            errors++;
            $display("CPU access to address %h never got uprdy", addr);
        end
    endtask

    task automatic write_word(input cfg_pkg::cfg_addr_t addr, input cfg_pkg::cfg_data_t data);
        int unsigned lat;
        cpu_access(1'b1, addr, data, lat);
        assert (lat == cfg_pkg::WR_LAT + cfg_pkg::RDY_LAT)
        else
        begin
            errors++;
            $display("Error: uprdy latency after upws is %h, expected %h",
                     lat, cfg_pkg::WR_LAT + cfg_pkg::RDY_LAT);
        end
    endtask

    // Grant is immediate with the scanner idle and bounded by one lap otherwise
    task automatic read_word(input cfg_pkg::cfg_addr_t addr, input logic scanning);
        int unsigned lat;
        cpu_access(1'b0, addr, '0, lat);
        assert (updo == model[addr])
        else
        begin
            errors++;
            $display("Error: updo at address %h is %h, expected %h", addr, updo, model[addr]);
        end
        assert (scanning ? (lat <= cfg_pkg::DEPTH + cfg_pkg::RDY_LAT + 1)
                         : (lat == cfg_pkg::RDY_LAT + 1))
        else
        begin
            errors++;
            $display("Error: uprdy latency after uprs is %h, expected %h", lat,
                     scanning ? cfg_pkg::DEPTH + cfg_pkg::RDY_LAT + 1 : cfg_pkg::RDY_LAT + 1);
        end
    endtask

    // Aim the write at the address the scanner reads in the RAM write cycle
    task automatic collide_write(input cfg_pkg::cfg_data_t data);
        cfg_pkg::cfg_addr_t addr;
        @(negedge clk);
        addr = cfg_pkg::cfg_addr_t'(eng_addr + 1 + cfg_pkg::WR_LAT + cfg_pkg::RD_LAT);
        write_word(addr, data);
    endtask

    ////////////////////
    // Watchdog
    initial
    begin
        repeat (NUM_OPS * (cfg_pkg::DEPTH + 10)) @(posedge clk);
        $display("Watchdog expired before the test sequence finished");
        $display("Test failures found");
        $finish;
    end

    ////////////////////
    // Test sequence
    initial
    begin
        void'($urandom(3));
        rst           = 1'b1;
        upen          = 1'b0;
        upws          = 1'b0;
        uprs          = 1'b0;
        upa           = '0;
        updi          = '0;
        scan_on       = 1'b0;
        gaps_on       = 1'b0;
        par_force_err = 1'b0;
        par_err_dis   = 1'b0;
        apply_reset();
        upen = 1'b1;

        // Fill and read back with the scanner idle
        for (int a = 0; a < N_FILL; a++)
            write_word(cfg_pkg::cfg_addr_t'(a), $urandom());
        for (int i = 0; i < N_RD; i++)
            read_word(cfg_pkg::cfg_addr_t'($urandom_range(cfg_pkg::DEPTH - 1)), 1'b0);

        // Reads against a running scanner with same-address grants first
        @(posedge clk);
        #1;
        scan_on = 1'b1;
        for (int i = 0; i < N_SCAN; i++)
        begin
            gaps_on = (i >= N_SCAN / 2);
            read_word(cfg_pkg::cfg_addr_t'($urandom_range(cfg_pkg::DEPTH - 1)), 1'b1);
        end

        // Writes that hit the scan address while the scanner runs without gaps
        gaps_on = 1'b0;
        repeat (cfg_pkg::RD_LAT + 2) @(posedge clk);
        for (int i = 0; i < N_COLL; i++)
            collide_write($urandom());
        gaps_on = 1'b1;
        for (int i = 0; i < N_COLL; i++)
            write_word(cfg_pkg::cfg_addr_t'($urandom_range(cfg_pkg::DEPTH - 1)), $urandom());
        for (int i = 0; i < N_COLL; i++)
            read_word(cfg_pkg::cfg_addr_t'($urandom_range(cfg_pkg::DEPTH - 1)), 1'b1);

        // Parity flag clean so far
        gaps_on = 1'b0;
        @(negedge clk);
        assert (par_err == 1'b0)
        else
        begin
            errors++;
            $display("Error: par_err is %h, expected %h", par_err, 1'b0);
        end
        @(posedge clk);
        #1;
        par_force_err = 1'b1;
        write_word(cfg_pkg::cfg_addr_t'($urandom_range(cfg_pkg::DEPTH - 1)), $urandom());
        @(posedge clk);
        #1;
        par_force_err = 1'b0;
        repeat (cfg_pkg::DEPTH + cfg_pkg::RD_LAT + 2) @(posedge clk);
        @(negedge clk);
        assert (par_err == 1'b1)
        else
        begin
            errors++;
            $display("Error: par_err is %h, expected %h", par_err, 1'b1);
        end

        // Bad word still stored with the flag disabled after a fresh reset
        @(posedge clk);
        #1;
        par_err_dis = 1'b1;
        scan_on     = 1'b0;
        apply_reset();
        scan_on = 1'b1;
        repeat (2 * cfg_pkg::DEPTH) @(posedge clk);
        @(negedge clk);
        assert (par_err == 1'b0)
        else
        begin
            errors++;
            $display("Error: par_err is %h, expected %h", par_err, 1'b0);
        end

        // Port disabled so updo must read zero
        @(posedge clk);
        #1;
        upen = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (eng_count == 0)
        begin
            errors++;
            $display("Engine never produced eng_valid");
        end

        $display("Data errors %0d, assertion errors %0d, engine words %0d",
                 errors, dut.u_assert.fail_count, eng_count);
        if (errors == 0 && dut.u_assert.fail_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* verilog/cfg_cpu_fsm.sv */
////////////////////
// CPU access state machine
// Turns upws/uprs strobes into a write pulse or a held read request
// and times the single-cycle uprdy pulse
////////////////////
`timescale 1ns/1ps

module cfg_cpu_fsm
(
    input  logic               clk,
    input  logic               rst,
    input  logic               upen,
    input  logic               upws,
    input  logic               uprs,
    input  cfg_pkg::cfg_addr_t upa,
    input  cfg_pkg::cfg_data_t updi,
    input  logic               rd_grant,
    output logic               wr_go,
    output cfg_pkg::cfg_addr_t wr_addr,
    output cfg_pkg::cfg_data_t wr_data,
    output logic               cpu_rd_req,
    output cfg_pkg::cfg_addr_t rd_addr,
    output logic               uprdy
);

    cfg_pkg::cpu_state_e state;
    cfg_pkg::cfg_cnt_t   cnt;

    ////////////////////
    // State and wait counter
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= cfg_pkg::IDLE;
            cnt   <= '0;
        end
        // Losing upen abandons the access
        else if (!upen)
        begin
            state <= cfg_pkg::IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                cfg_pkg::IDLE:
                begin
                    // Write wins if both strobes arrive together
                    if (upws)
                    begin
                        state <= cfg_pkg::WR_WAIT;
                        cnt   <= cfg_pkg::cfg_cnt_t'(cfg_pkg::WR_LAT - 1);
                    end
                    else if (uprs)
                    begin
                        state <= cfg_pkg::RD_PEND;
                    end
                end
                cfg_pkg::WR_WAIT:
                begin
                    // RAM write lands in the last WR_WAIT cycle
                    if (cnt == '0)
                    begin
                        state <= cfg_pkg::DONE_WAIT;
                        cnt   <= cfg_pkg::cfg_cnt_t'(cfg_pkg::RDY_LAT - 1);
                    end
                    else
                    begin
                        cnt <= cnt - 1'b1;
                    end
                end
                cfg_pkg::RD_PEND:
                begin
                    if (rd_grant)
                    begin
                        state <= cfg_pkg::DONE_WAIT;
                        cnt   <= cfg_pkg::cfg_cnt_t'(cfg_pkg::RDY_LAT - 1);
                    end
                end
                default:
                begin
                    // DONE_WAIT, back to idle after the ready cycle
                    if (cnt == '0)
                        state <= cfg_pkg::IDLE;
                    else
                        cnt <= cnt - 1'b1;
                end
            endcase
        end
    end

    ////////////////////
    // Outputs
    // Write pulse in first WR_WAIT cycle, arbiter registers it once more
    assign wr_go = upen && (state == cfg_pkg::WR_WAIT) &&
                   (cnt == cfg_pkg::cfg_cnt_t'(cfg_pkg::WR_LAT - 1));

    // CPU holds upa and updi until uprdy
    assign wr_addr = upa;
    assign wr_data = updi;
    assign rd_addr = upa;

    assign cpu_rd_req = upen && (state == cfg_pkg::RD_PEND);
    assign uprdy      = upen && (state == cfg_pkg::DONE_WAIT) && (cnt == '0);

endmodule

/* verilog/cfg_delay_pipe.sv */
////////////////////
// Fixed-depth delay pipe
// Carries one payload per cycle through RD_LAT register stages
////////////////////
`timescale 1ns/1ps

module cfg_delay_pipe
#(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     rst,
    input  payload_t in,
    output payload_t out
);

    payload_t stage [cfg_pkg::RD_LAT];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < cfg_pkg::RD_LAT; i++)
                stage[i] <= '0;
        end
        else
        begin
            stage[0] <= in;
            // Shift toward the exit
            for (int i = 1; i < cfg_pkg::RD_LAT; i++)
                stage[i] <= stage[i-1];
        end
    end

    assign out = stage[cfg_pkg::RD_LAT-1];

endmodule

/* verilog/cfg_pkg.sv */
////////////////////
// Configuration table shared definitions
// Sizes, latencies, RAM port structs, read tags and CPU FSM states
////////////////////

package cfg_pkg;

    ////////////////////
    // Table geometry
    localparam int ADDR_W = 5;
    localparam int DATA_W = 32;
    localparam int DEPTH  = 32;

    ////////////////////
    // Latencies in clock cycles
    // RAM read enable to read data
    localparam int RD_LAT  = 3;
    // CPU write strobe to RAM write, covers parity generation
    localparam int WR_LAT  = 2;
    // Access performed to uprdy
    localparam int RDY_LAT = 4;

    // CPU FSM down-counter, wide enough for either wait
    localparam int CNT_W = $clog2(WR_LAT + RDY_LAT);

    typedef logic [ADDR_W-1:0] cfg_addr_t;
    typedef logic [DATA_W-1:0] cfg_data_t;
    typedef logic [CNT_W-1:0]  cfg_cnt_t;

    // Stored word, even parity over data
    typedef struct packed {
        logic      par;
        cfg_data_t data;
    } cfg_word_t;

    // RAM write port
    typedef struct packed {
        logic      en;
        cfg_addr_t addr;
        cfg_word_t word;
    } mem_wr_t;

    // RAM read port
    typedef struct packed {
        logic      en;
        cfg_addr_t addr;
    } mem_rd_t;

    // Rides beside a read until its data returns
    // eng and cpu say who gets the data, fwd marks a collision
    typedef struct packed {
        logic      eng;
        logic      cpu;
        logic      fwd;
        cfg_addr_t addr;
    } rd_tag_t;

    // CPU access states
    typedef enum logic [1:0] {
        IDLE,
        WR_WAIT,
        RD_PEND,
        DONE_WAIT
    } cpu_state_e;

endpackage

/* verilog/cfg_port_arb.sv */
////////////////////
// Port arbiter
// Engine reads first, CPU read on a free cycle or a shared address
// Collision forwarding, parity generate and check, sticky par_err
////////////////////
`timescale 1ns/1ps

module cfg_port_arb
(
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_go,
    input  cfg_pkg::cfg_addr_t wr_addr,
    input  cfg_pkg::cfg_data_t wr_data,
    input  logic               cpu_rd_req,
    input  cfg_pkg::cfg_addr_t rd_addr,
    input  cfg_pkg::mem_rd_t   eng_rd,
    input  cfg_pkg::cfg_word_t mem_rdata,
    input  logic               par_force_err,
    input  logic               par_err_dis,
    input  logic               upen,
    output logic               rd_grant,
    output cfg_pkg::mem_wr_t   mem_wr,
    output cfg_pkg::mem_rd_t   mem_rd,
    output logic               eng_valid,
    output cfg_pkg::cfg_addr_t eng_addr,
    output cfg_pkg::cfg_data_t eng_data,
    output cfg_pkg::cfg_data_t updo,
    output logic               par_err
);

    logic               wr_en_q;
    cfg_pkg::cfg_addr_t wr_addr_q;
    cfg_pkg::cfg_word_t wr_word_q;

    cfg_pkg::mem_rd_t   rd_sel;
    logic               collide;

    cfg_pkg::rd_tag_t   tag_in;
    cfg_pkg::rd_tag_t   tag_out;
    cfg_pkg::cfg_word_t fwd_in;
    cfg_pkg::cfg_word_t fwd_out;

    cfg_pkg::cfg_word_t rd_word;
    logic               rd_chk;
    cfg_pkg::cfg_data_t updo_q;

    ////////////////////
    // Write path
    // Second WR_LAT stage, parity computed here
    always_ff @(posedge clk)
    begin
        if (rst)
            wr_en_q <= 1'b0;
        else
            wr_en_q <= wr_go;
    end

    always_ff @(posedge clk)
    begin
        if (wr_go)
        begin
            wr_addr_q      <= wr_addr;
            wr_word_q.data <= wr_data;
            // Even parity, flipped on purpose when forcing errors
            wr_word_q.par  <= (^wr_data) ^ par_force_err;
        end
    end

    assign mem_wr.en   = wr_en_q;
    assign mem_wr.addr = wr_addr_q;
    assign mem_wr.word = wr_word_q;

    ////////////////////
    // Read arbitration
    // Engine owns the port when reading, CPU rides along on same address
    assign rd_grant = cpu_rd_req && (!eng_rd.en || (eng_rd.addr == rd_addr));

    assign rd_sel.en   = eng_rd.en || rd_grant;
    assign rd_sel.addr = eng_rd.en ? eng_rd.addr : rd_addr;

    // Read of the word being written this cycle
    assign collide = rd_sel.en && mem_wr.en && (mem_wr.addr == rd_sel.addr);

    // RAM would return the old word, so skip it
    assign mem_rd.en   = rd_sel.en && !collide;
    assign mem_rd.addr = rd_sel.addr;

    ////////////////////
    // In-flight reads
    assign tag_in.eng  = eng_rd.en;
    assign tag_in.cpu  = rd_grant;
    assign tag_in.fwd  = collide;
    assign tag_in.addr = rd_sel.addr;

    assign fwd_in = collide ? mem_wr.word : '0;

    cfg_delay_pipe #(.payload_t(cfg_pkg::rd_tag_t)) u_tag_pipe
    (
        .clk (clk),
        .rst (rst),
        .in  (tag_in),
        .out (tag_out)
    );

    cfg_delay_pipe #(.payload_t(cfg_pkg::cfg_word_t)) u_fwd_pipe
    (
        .clk (clk),
        .rst (rst),
        .in  (fwd_in),
        .out (fwd_out)
    );

    ////////////////////
    // Pipe exit
    assign rd_word = tag_out.fwd ? fwd_out : mem_rdata;

    // Engine sees data straight at the exit
    assign eng_valid = tag_out.eng;
    assign eng_addr  = tag_out.addr;
    assign eng_data  = rd_word.data;

    // CPU data one cycle later, lines up with uprdy
    always_ff @(posedge clk)
    begin
        if (tag_out.cpu)
            updo_q <= rd_word.data;
    end

    assign updo = upen ? updo_q : '0;

    ////////////////////
    // Parity check
    // Only real RAM reads, forwarded words never hit storage
    assign rd_chk = (tag_out.eng || tag_out.cpu) && !tag_out.fwd;

    // Sticky until rst
    always_ff @(posedge clk)
    begin
        if (rst)
            par_err <= 1'b0;
        else if (rd_chk && !par_err_dis && (^mem_rdata))
            par_err <= 1'b1;
    end

endmodule

/* verilog/cfg_ram.sv */
////////////////////
// Table storage
// DEPTH parity-protected words with one write and one read per cycle
// Read data comes out of a RD_LAT register pipeline
////////////////////
`timescale 1ns/1ps

module cfg_ram
(
    input  logic               clk,
    input  cfg_pkg::mem_wr_t   wr,
    input  cfg_pkg::mem_rd_t   rd,
    output cfg_pkg::cfg_word_t rdata
);

    cfg_pkg::cfg_word_t mem [cfg_pkg::DEPTH];
    cfg_pkg::cfg_word_t rd_pipe [cfg_pkg::RD_LAT];

    ////////////////////
    // Write port
    always_ff @(posedge clk)
    begin
        if (wr.en)
            mem[wr.addr] <= wr.word;
    end

    ////////////////////
    // Read port
    always_ff @(posedge clk)
    begin
        // Same-address write in this cycle is not seen so the old word comes out
        if (rd.en)
            rd_pipe[0] <= mem[rd.addr];
        // Output registers for a total latency of RD_LAT
        for (int i = 1; i < cfg_pkg::RD_LAT; i++)
            rd_pipe[i] <= rd_pipe[i-1];
    end

    assign rdata = rd_pipe[cfg_pkg::RD_LAT-1];

endmodule

/* verilog/cfg_scan_counter.sv */
////////////////////
// Engine scan counter
// Reads one table address per cycle while active, wrapping at DEPTH
////////////////////
`timescale 1ns/1ps

module cfg_scan_counter
(
    input  logic             clk,
    input  logic             rst,
    input  logic             active,
    output cfg_pkg::mem_rd_t eng_rd
);

    cfg_pkg::cfg_addr_t scan_addr;
    logic               at_last;

    // Last table entry, next read goes back to zero
    assign at_last = (scan_addr == cfg_pkg::cfg_addr_t'(cfg_pkg::DEPTH - 1));

    ////////////////////
    // Address counter
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            scan_addr <= '0;
        end
        else if (active)
        begin
            if (at_last)
                scan_addr <= '0;
            else
                scan_addr <= scan_addr + 1'b1;
        end
        // Inactive, hold position
    end

    // One read per active cycle
    assign eng_rd.en   = active;
    assign eng_rd.addr = scan_addr;

endmodule

/* verilog/cfg_table_top.sv */
////////////////////
// Configuration table top level
// CPU port and engine scanner sharing one parity-protected RAM
////////////////////
`timescale 1ns/1ps

module cfg_table_top
(
    input  logic               clk,
    input  logic               rst,
    // CPU side
    input  logic               upen,
    input  logic               upws,
    input  logic               uprs,
    input  cfg_pkg::cfg_addr_t upa,
    input  cfg_pkg::cfg_data_t updi,
    output cfg_pkg::cfg_data_t updo,
    output logic               uprdy,
    // Engine side
    input  logic               active,
    output logic               eng_valid,
    output cfg_pkg::cfg_addr_t eng_addr,
    output cfg_pkg::cfg_data_t eng_data,
    // Static config and status
    input  logic               par_force_err,
    input  logic               par_err_dis,
    output logic               par_err
);

    logic               wr_go;
    cfg_pkg::cfg_addr_t wr_addr;
    cfg_pkg::cfg_data_t wr_data;
    logic               cpu_rd_req;
    cfg_pkg::cfg_addr_t rd_addr;
    logic               rd_grant;
    cfg_pkg::mem_rd_t   eng_rd;
    cfg_pkg::mem_wr_t   mem_wr;
    cfg_pkg::mem_rd_t   mem_rd;
    cfg_pkg::cfg_word_t mem_rdata;

    cfg_cpu_fsm u_cpu_fsm
    (
        .clk        (clk),
        .rst        (rst),
        .upen       (upen),
        .upws       (upws),
        .uprs       (uprs),
        .upa        (upa),
        .updi       (updi),
        .rd_grant   (rd_grant),
        .wr_go      (wr_go),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .cpu_rd_req (cpu_rd_req),
        .rd_addr    (rd_addr),
        .uprdy      (uprdy)
    );

    cfg_scan_counter u_scan
    (
        .clk    (clk),
        .rst    (rst),
        .active (active),
        .eng_rd (eng_rd)
    );

    cfg_port_arb u_arb
    (
        .clk           (clk),
        .rst           (rst),
        .wr_go         (wr_go),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .cpu_rd_req    (cpu_rd_req),
        .rd_addr       (rd_addr),
        .eng_rd        (eng_rd),
        .mem_rdata     (mem_rdata),
        .par_force_err (par_force_err),
        .par_err_dis   (par_err_dis),
        .upen          (upen),
        .rd_grant      (rd_grant),
        .mem_wr        (mem_wr),
        .mem_rd        (mem_rd),
        .eng_valid     (eng_valid),
        .eng_addr      (eng_addr),
        .eng_data      (eng_data),
        .updo          (updo),
        .par_err       (par_err)
    );

    cfg_ram u_ram
    (
        .clk   (clk),
        .wr    (mem_wr),
        .rd    (mem_rd),
        .rdata (mem_rdata)
    );

endmodule
